// ==== Makefile ====
# Verilator build and run for the out-of-order back end

VERILATOR ?= verilator
TOP       ?= tb_backend
FILELIST  ?= ooo_backend.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= NO ERRORS

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== ooo_backend.f ====
rtl/backend_pkg.sv
rtl/issue_if.sv
rtl/dispatch.sv
rtl/issue_queue.sv
rtl/alu_unit.sv
rtl/mul_unit.sv
rtl/commit.sv
rtl/backend.sv
sim/tb_backend.sv

// ==== rtl/alu_unit.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single-cycle integer unit: add, sub, and, xor
// result and tag registered one cycle after the input
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module alu_unit (
	input  logic              CLK,
	input  logic              i_reset,
	input  logic              i_valid,
	input  backend_pkg::uop_t i_uop,
	output backend_pkg::wb_t  o_wb
);
	import backend_pkg::*;

	logic [XLEN-1:0]  result;
	logic             wb_valid;
	logic [TAG_W-1:0] wb_tag;
	logic [XLEN-1:0]  wb_data;

	always_comb begin
		case (i_uop.op)
			OP_ADD:  result = i_uop.src1 + i_uop.src2;
			OP_SUB:  result = i_uop.src1 - i_uop.src2;
			OP_AND:  result = i_uop.src1 & i_uop.src2;
			OP_XOR:  result = i_uop.src1 ^ i_uop.src2;
			// multiplies go to the other path
			default: result = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (i_reset)
			wb_valid <= 1'b0;
		else
			wb_valid <= i_valid;
	end

	always_ff @(posedge CLK) begin
		wb_tag  <= i_uop.tag;
		wb_data <= result;
	end

	assign o_wb = '{valid: wb_valid, tag: wb_tag, data: wb_data};

endmodule

// ==== rtl/backend.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// out-of-order back end top: dispatch, ALU and multiply paths, commit
// ops enter on a valid/ready handshake and retire in program order
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module backend (
	input  logic                           CLK,
	input  logic                           i_reset,
	input  logic                           i_instr_valid,
	input  backend_pkg::op_e               i_instr_op,
	input  logic [backend_pkg::AREG_W-1:0] i_instr_rd,
	input  logic [backend_pkg::AREG_W-1:0] i_instr_rs1,
	input  logic [backend_pkg::AREG_W-1:0] i_instr_rs2,
	output logic                           o_instr_ready,
	output logic                           o_retire_valid,
	output logic [backend_pkg::TAG_W-1:0]  o_retire_tag,
	output logic [backend_pkg::AREG_W-1:0] o_retire_rd,
	output logic [backend_pkg::XLEN-1:0]   o_retire_data
);
	import backend_pkg::*;

	issue_if alu_if ();
	issue_if mul_if ();

	logic [AREG_W-1:0] rs1_idx, rs2_idx, alloc_rd;
	logic [XLEN-1:0]   rs1_data, rs2_data;
	logic              alloc_valid, rob_credit;
	logic              alu_valid, mul_valid;
	uop_t              alu_uop, mul_uop;
	wb_t               alu_wb, mul_wb;

	dispatch u_dispatch (
		.CLK(CLK), .i_reset(i_reset),
		.i_instr_valid(i_instr_valid), .i_instr_op(i_instr_op),
		.i_instr_rd(i_instr_rd), .i_instr_rs1(i_instr_rs1), .i_instr_rs2(i_instr_rs2),
		.o_instr_ready(o_instr_ready),
		.alu_port(alu_if.dispatcher), .mul_port(mul_if.dispatcher),
		.o_rs1_idx(rs1_idx), .o_rs2_idx(rs2_idx),
		.i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
		.o_alloc_valid(alloc_valid), .o_alloc_rd(alloc_rd),
		.i_rob_credit(rob_credit),
		.i_retire_valid(o_retire_valid), .i_retire_rd(o_retire_rd)
	);

	issue_queue #(.DEPTH(ALU_IQ_DEPTH)) alu_queue (
		.CLK(CLK), .i_reset(i_reset), .port(alu_if.queue),
		.o_valid(alu_valid), .o_uop(alu_uop)
	);

	issue_queue #(.DEPTH(MUL_IQ_DEPTH)) mul_queue (
		.CLK(CLK), .i_reset(i_reset), .port(mul_if.queue),
		.o_valid(mul_valid), .o_uop(mul_uop)
	);

	alu_unit u_alu (
		.CLK(CLK), .i_reset(i_reset),
		.i_valid(alu_valid), .i_uop(alu_uop), .o_wb(alu_wb)
	);

	mul_unit u_mul (
		.CLK(CLK), .i_reset(i_reset),
		.i_valid(mul_valid), .i_uop(mul_uop), .o_wb(mul_wb)
	);

	commit u_commit (
		.CLK(CLK), .i_reset(i_reset),
		.i_alu_wb(alu_wb), .i_mul_wb(mul_wb),
		.i_alloc_valid(alloc_valid), .i_alloc_rd(alloc_rd),
		.i_rs1_idx(rs1_idx), .i_rs2_idx(rs2_idx),
		.o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
		.o_rob_credit(rob_credit),
		.o_retire_valid(o_retire_valid), .o_retire_tag(o_retire_tag),
		.o_retire_rd(o_retire_rd), .o_retire_data(o_retire_data)
	);

endmodule

// ==== rtl/backend_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizes, opcodes and payload types shared by the back end
// import into each module body that needs them
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package backend_pkg;

	// datapath and register file
	localparam int XLEN      = 32;
	localparam int NUM_AREGS = 8;
	localparam int AREG_W    = 3;

	// reorder buffer, depth must be 2**TAG_W
	localparam int ROB_DEPTH = 8;
	localparam int TAG_W     = 3;

	// issue queue sizes, also the initial credit counts
	localparam int ALU_IQ_DEPTH = 4;
	localparam int MUL_IQ_DEPTH = 2;

	localparam int MUL_STAGES = 3;

	// wide enough for the largest credit pool
	localparam int CRED_W = $clog2(ROB_DEPTH + 1);

	typedef enum logic [2:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_XOR,
		OP_MUL
	} op_e;

	// op as it leaves dispatch with operands already read
	typedef struct packed {
		op_e              op;
		logic [TAG_W-1:0] tag;
		logic [XLEN-1:0]  src1;
		logic [XLEN-1:0]  src2;
	} uop_t;

	// finished result heading for the ROB
	typedef struct packed {
		logic             valid;
		logic [TAG_W-1:0] tag;
		logic [XLEN-1:0]  data;
	} wb_t;

endpackage

// ==== rtl/commit.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reorder buffer plus architectural register file
// collects both result streams, retires one op per cycle in order
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module commit (
	input  logic                           CLK,
	input  logic                           i_reset,
	input  backend_pkg::wb_t               i_alu_wb,
	input  backend_pkg::wb_t               i_mul_wb,
	input  logic                           i_alloc_valid,
	input  logic [backend_pkg::AREG_W-1:0] i_alloc_rd,
	input  logic [backend_pkg::AREG_W-1:0] i_rs1_idx,
	input  logic [backend_pkg::AREG_W-1:0] i_rs2_idx,
	output logic [backend_pkg::XLEN-1:0]   o_rs1_data,
	output logic [backend_pkg::XLEN-1:0]   o_rs2_data,
	output logic                           o_rob_credit,
	output logic                           o_retire_valid,
	output logic [backend_pkg::TAG_W-1:0]  o_retire_tag,
	output logic [backend_pkg::AREG_W-1:0] o_retire_rd,
	output logic [backend_pkg::XLEN-1:0]   o_retire_data
);
	import backend_pkg::*;

	logic [AREG_W-1:0]    rob_rd   [ROB_DEPTH];
	logic [XLEN-1:0]      rob_data [ROB_DEPTH];
	logic [ROB_DEPTH-1:0] rob_done;
	logic [TAG_W-1:0]     head, tail;
	logic [XLEN-1:0]      regs [NUM_AREGS];
	logic                 retire;

	// head result was written back at least one cycle ago
	assign retire = rob_done[head];

	always_ff @(posedge CLK) begin
		if (i_reset) begin
			rob_done <= '0;
			head     <= '0;
			tail     <= '0;
		end else begin
			// pointers wrap on their own, depth is a power of two
			if (i_alloc_valid)
				tail <= tail + 1'b1;
			if (retire) begin
				rob_done[head] <= 1'b0;
				head           <= head + 1'b1;
			end
			if (i_alu_wb.valid)
				rob_done[i_alu_wb.tag] <= 1'b1;
			if (i_mul_wb.valid)
				rob_done[i_mul_wb.tag] <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (i_alloc_valid)
			rob_rd[tail] <= i_alloc_rd;
		if (i_alu_wb.valid)
			rob_data[i_alu_wb.tag] <= i_alu_wb.data;
		if (i_mul_wb.valid)
			rob_data[i_mul_wb.tag] <= i_mul_wb.data;
	end

	// architectural state, updated only at retirement
	always_ff @(posedge CLK) begin
		if (i_reset) begin
			for (int i = 0; i < NUM_AREGS; i++)
				regs[i] <= '0;
		end else if (retire) begin
			regs[rob_rd[head]] <= rob_data[head];
		end
	end

	assign o_rs1_data = regs[i_rs1_idx];
	assign o_rs2_data = regs[i_rs2_idx];

	assign o_rob_credit   = retire;
	assign o_retire_valid = retire;
	assign o_retire_tag   = head;
	assign o_retire_rd    = rob_rd[head];
	assign o_retire_data  = rob_data[head];

endmodule

// ==== rtl/dispatch.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// in-order dispatch: hazard check, operand read, tag and credits
// accepted ops reach the selected queue one cycle later
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module dispatch (
	input  logic                          CLK,
	input  logic                          i_reset,
	input  logic                          i_instr_valid,
	input  backend_pkg::op_e              i_instr_op,
	input  logic [backend_pkg::AREG_W-1:0] i_instr_rd,
	input  logic [backend_pkg::AREG_W-1:0] i_instr_rs1,
	input  logic [backend_pkg::AREG_W-1:0] i_instr_rs2,
	output logic                          o_instr_ready,
	issue_if.dispatcher                   alu_port,
	issue_if.dispatcher                   mul_port,
	output logic [backend_pkg::AREG_W-1:0] o_rs1_idx,
	output logic [backend_pkg::AREG_W-1:0] o_rs2_idx,
	input  logic [backend_pkg::XLEN-1:0]   i_rs1_data,
	input  logic [backend_pkg::XLEN-1:0]   i_rs2_data,
	output logic                          o_alloc_valid,
	output logic [backend_pkg::AREG_W-1:0] o_alloc_rd,
	input  logic                          i_rob_credit,
	input  logic                          i_retire_valid,
	input  logic [backend_pkg::AREG_W-1:0] i_retire_rd
);
	import backend_pkg::*;

	logic [NUM_AREGS-1:0] busy;
	logic [TAG_W-1:0]     tag_q;
	logic [CRED_W-1:0]    rob_cred, alu_cred, mul_cred;
	logic                 cred_loaded;
	logic                 is_mul, hazard, accept;
	logic                 alu_valid_q, mul_valid_q;
	uop_t                 uop_q;

	assign is_mul = (i_instr_op == OP_MUL);
	assign hazard = busy[i_instr_rs1] | busy[i_instr_rs2] | busy[i_instr_rd];

	assign o_instr_ready = (rob_cred != '0) && !hazard &&
		(is_mul ? (mul_cred != '0) : (alu_cred != '0));
	assign accept = i_instr_valid & o_instr_ready;

	assign o_rs1_idx     = i_instr_rs1;
	assign o_rs2_idx     = i_instr_rs2;
	assign o_alloc_valid = accept;
	assign o_alloc_rd    = i_instr_rd;

	assign alu_port.valid = alu_valid_q;
	assign alu_port.uop   = uop_q;
	assign mul_port.valid = mul_valid_q;
	assign mul_port.uop   = uop_q;

	always_ff @(posedge CLK) begin
		if (i_reset) begin
			busy        <= '0;
			tag_q       <= '0;
			alu_valid_q <= 1'b0;
			mul_valid_q <= 1'b0;
		end else begin
			// retire clears before accept sets; the two never hit the same rd
			if (i_retire_valid)
				busy[i_retire_rd] <= 1'b0;
			if (accept) begin
				busy[i_instr_rd] <= 1'b1;
				tag_q            <= tag_q + 1'b1;
			end
			alu_valid_q <= accept & ~is_mul;
			mul_valid_q <= accept & is_mul;
		end
	end

	// counters load in the first cycle out of reset
	always_ff @(posedge CLK) begin
		if (i_reset) begin
			cred_loaded <= 1'b0;
			rob_cred    <= '0;
			alu_cred    <= '0;
			mul_cred    <= '0;
		end else if (!cred_loaded) begin
			cred_loaded <= 1'b1;
			rob_cred    <= CRED_W'(ROB_DEPTH);
			alu_cred    <= CRED_W'(ALU_IQ_DEPTH);
			mul_cred    <= CRED_W'(MUL_IQ_DEPTH);
		end else begin
			rob_cred <= rob_cred + CRED_W'(i_rob_credit) - CRED_W'(accept);
			alu_cred <= alu_cred + CRED_W'(alu_port.credit) - CRED_W'(accept & ~is_mul);
			mul_cred <= mul_cred + CRED_W'(mul_port.credit) - CRED_W'(accept & is_mul);
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) begin
			uop_q.op   <= i_instr_op;
			uop_q.tag  <= tag_q;
			uop_q.src1 <= i_rs1_data;
			uop_q.src2 <= i_rs2_data;
		end
	end

endmodule

// ==== rtl/issue_if.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dispatcher to issue queue link with credit return
// one instance per execution path
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface issue_if;
	import backend_pkg::*;

	logic valid;
	uop_t uop;
	// one pulse per popped entry
	logic credit;

	modport dispatcher (
		output valid,
		output uop,
		input  credit
	);

	modport queue (
		input  valid,
		input  uop,
		output credit
	);

endinterface

// ==== rtl/issue_queue.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// circular FIFO between dispatch and one execution unit
// pops every non-empty cycle, returns one credit per pop
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module issue_queue #(
	parameter int DEPTH = 4
) (
	input  logic              CLK,
	input  logic              i_reset,
	issue_if.queue            port,
	output logic              o_valid,
	output backend_pkg::uop_t o_uop
);
	import backend_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	uop_t             mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] count;
	logic             pop;
	logic             pop_q;
	uop_t             uop_q;

	// units take one op per cycle, so the head always leaves
	assign pop = (count != '0);

	always_ff @(posedge CLK) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			pop_q  <= 1'b0;
		end else begin
			if (port.valid)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// no full check, credits keep count within DEPTH
			count <= count + CNT_W'(port.valid) - CNT_W'(pop);
			pop_q <= pop;
		end
	end

	always_ff @(posedge CLK) begin
		if (port.valid)
			mem[wr_ptr] <= port.uop;
		if (pop)
			uop_q <= mem[rd_ptr];
	end

	assign o_valid     = pop_q;
	assign o_uop       = uop_q;
	assign port.credit = pop_q;

endmodule

// ==== rtl/mul_unit.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pipelined 32-bit multiplier returning the low product word
// fully pipelined, one op per cycle, result after MUL_STAGES
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mul_unit (
	input  logic              CLK,
	input  logic              i_reset,
	input  logic              i_valid,
	input  backend_pkg::uop_t i_uop,
	output backend_pkg::wb_t  o_wb
);
	import backend_pkg::*;

	logic [MUL_STAGES-1:0] vld_q;
	logic [TAG_W-1:0]      tag_q [MUL_STAGES];

	// stage 1: 16-bit partial products, cross terms kept to 16 bits
	logic [XLEN-1:0] s1_ll;
	logic [15:0]     s1_lh, s1_hl;
	// stage 2: cross terms summed
	logic [XLEN-1:0] s2_ll;
	logic [15:0]     s2_cross;
	// stage 3: low product word
	logic [XLEN-1:0] s3_prod;

	always_ff @(posedge CLK) begin
		if (i_reset)
			vld_q <= '0;
		else
			vld_q <= {vld_q[MUL_STAGES-2:0], i_valid};
	end

	always_ff @(posedge CLK) begin
		tag_q[0] <= i_uop.tag;
		for (int i = 1; i < MUL_STAGES; i++)
			tag_q[i] <= tag_q[i-1];

		s1_ll    <= {16'h0, i_uop.src1[15:0]} * {16'h0, i_uop.src2[15:0]};
		s1_lh    <= i_uop.src1[15:0] * i_uop.src2[31:16];
		s1_hl    <= i_uop.src1[31:16] * i_uop.src2[15:0];
		s2_ll    <= s1_ll;
		s2_cross <= s1_lh + s1_hl;
		s3_prod  <= s2_ll + {s2_cross, 16'h0};
	end

	assign o_wb = '{valid: vld_q[MUL_STAGES-1], tag: tag_q[MUL_STAGES-1], data: s3_prod};

endmodule

// ==== sim/tb_backend.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// random-stimulus testbench for the back end top level
// an in-order model predicts every retirement; run through the Makefile
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_backend;
	import backend_pkg::*;

	localparam int SEND_TIMEOUT  = 100;
	localparam int DRAIN_TIMEOUT = 400;

	logic              CLK;
	logic              i_reset;
	logic              i_instr_valid;
	op_e               i_instr_op;
	logic [AREG_W-1:0] i_instr_rd, i_instr_rs1, i_instr_rs2;
	logic              o_instr_ready;
	logic              o_retire_valid;
	logic [TAG_W-1:0]  o_retire_tag;
	logic [AREG_W-1:0] o_retire_rd;
	logic [XLEN-1:0]   o_retire_data;

	logic [31:0]       lfsr;
	logic [XLEN-1:0]   model_regs [NUM_AREGS];
	logic [TAG_W-1:0]  model_tag;
	logic [TAG_W-1:0]  exp_tag [$];
	logic [AREG_W-1:0] exp_rd [$];
	logic [XLEN-1:0]   exp_data [$];
	int                errors, accepted, retired, stalls;

	backend dut (
		.CLK(CLK), .i_reset(i_reset),
		.i_instr_valid(i_instr_valid), .i_instr_op(i_instr_op),
		.i_instr_rd(i_instr_rd), .i_instr_rs1(i_instr_rs1), .i_instr_rs2(i_instr_rs2),
		.o_instr_ready(o_instr_ready),
		.o_retire_valid(o_retire_valid), .o_retire_tag(o_retire_tag),
		.o_retire_rd(o_retire_rd), .o_retire_data(o_retire_data)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	// feedback x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [XLEN-1:0] model_result(input op_e op, input logic [XLEN-1:0] a,
		input logic [XLEN-1:0] b);
		case (op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_XOR:  return a ^ b;
			default: return a * b;
		endcase
	endfunction

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			errors++;
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic finish_run();
		$display("accepted %0d, retired %0d, errors %0d", accepted, retired, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	endtask

	task automatic idle();
		@(posedge CLK);
		#2;
	endtask

	// offer one op and hold it until the DUT takes it
	task automatic send_op(input op_e op, input logic [AREG_W-1:0] rd, rs1, rs2);
		int              waited;
		logic [XLEN-1:0] res;
		waited        = 0;
		i_instr_valid = 1'b1;
		i_instr_op    = op;
		i_instr_rd    = rd;
		i_instr_rs1   = rs1;
		i_instr_rs2   = rs2;
		@(negedge CLK);
		while (!o_instr_ready && waited <= SEND_TIMEOUT) begin
			stalls++;
			waited++;
			@(negedge CLK);
		end
		if (waited > SEND_TIMEOUT) begin
			errors++;
			$display("timeout at %0t ns: offered op was never accepted", $time);
			finish_run();
		end else begin
			// model result in program order
			res            = model_result(op, model_regs[rs1], model_regs[rs2]);
			model_regs[rd] = res;
			exp_tag.push_back(model_tag);
			exp_rd.push_back(rd);
			exp_data.push_back(res);
			model_tag++;
			accepted++;
			@(posedge CLK);
			#2;
			i_instr_valid = 1'b0;
		end
	endtask

	// mode 0 ALU only, 1 ALU and multiply, 2 mixed on r0 and r1, 3 multiply only
	task automatic send_random(input int mode);
		op_e               op;
		logic [AREG_W-1:0] rd, rs1, rs2;
		logic [31:0]       v;
		if (mode == 3) begin
			op = OP_MUL;
		end else if (mode == 0) begin
			v  = rand_bits(2);
			op = op_e'(v[2:0]);
		end else begin
			v  = rand_bits(3);
			op = (v >= 4) ? OP_MUL : op_e'(v[2:0]);
		end
		if (mode == 3) begin
			// rd rotates over r0 to r5 while sources stay on r6 and r7
			rd  = AREG_W'(accepted % 6);
			v   = rand_bits(1);
			rs1 = AREG_W'(6 + v);
			v   = rand_bits(1);
			rs2 = AREG_W'(6 + v);
		end else begin
			v   = (mode == 2) ? rand_bits(1) : rand_bits(3);
			rd  = v[AREG_W-1:0];
			v   = (mode == 2) ? rand_bits(1) : rand_bits(3);
			rs1 = v[AREG_W-1:0];
			v   = (mode == 2) ? rand_bits(1) : rand_bits(3);
			rs2 = v[AREG_W-1:0];
		end
		send_op(op, rd, rs1, rs2);
	endtask

	// retirements are checked one cycle at a time in accepted order
	always @(negedge CLK) begin
		if (!i_reset && o_retire_valid) begin
			if (exp_tag.size() == 0) begin
				errors++;
				$display("error at %0t ns: retirement with no accepted op outstanding", $time);
			end else begin
				check(32'(o_retire_tag), 32'(exp_tag.pop_front()), "retire tag");
				check(32'(o_retire_rd), 32'(exp_rd.pop_front()), "retire rd");
				check(o_retire_data, exp_data.pop_front(), "retire data");
			end
			retired++;
		end
	end

	initial begin
		int waited;
		int burst_stalls;
		lfsr          = 32'ha298b8ad;
		errors        = 0;
		accepted      = 0;
		retired       = 0;
		stalls        = 0;
		model_tag     = '0;
		i_reset       = 1'b1;
		i_instr_valid = 1'b0;
		i_instr_op    = OP_ADD;
		i_instr_rd    = '0;
		i_instr_rs1   = '0;
		i_instr_rs2   = '0;
		for (int i = 0; i < NUM_AREGS; i++)
			model_regs[i] = '0;

		repeat (16) begin
			@(posedge CLK);
			#2;
			check(32'(o_instr_ready), 32'd0, "ready during reset");
			check(32'(o_retire_valid), 32'd0, "retire valid during reset");
		end
		i_reset = 1'b0;

		for (int n = 0; n < 60; n++) begin
			if (rand_bits(1) == 32'd1)
				send_random(0);
			else
				idle();
		end
		for (int n = 0; n < 80; n++) begin
			if (rand_bits(1) == 32'd1)
				send_random(1);
			else
				idle();
		end
		// back to back on two registers
		for (int n = 0; n < 40; n++)
			send_random(2);

		// let the two-register ops retire so the burst sees no hazard
		repeat (10) idle();

		burst_stalls = stalls;
		for (int n = 0; n < 20; n++)
			send_random(3);
		check((stalls > burst_stalls) ? 32'd1 : 32'd0, 32'd1, "ready drop in multiply burst");

		waited = 0;
		while (exp_tag.size() != 0 && waited <= DRAIN_TIMEOUT) begin
			@(posedge CLK);
			waited++;
		end
		if (waited > DRAIN_TIMEOUT) begin
			errors++;
			$display("timeout at %0t ns: %0d accepted ops never retired", $time, exp_tag.size());
			finish_run();
		end else begin
			// anything retiring from here on is an extra op
			repeat (50) @(posedge CLK);
			check(32'(retired), 32'(accepted), "retirement count");
			finish_run();
		end
	end

endmodule
